// File: logic/sd_pkg.sv
package sd_pkg;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;
    localparam int ARG_W      = 32;
    localparam int CMD_IDX_W  = 6;
    localparam int RESP_W     = 120;   // short status sits in the low 32 bits
    localparam int NCR_MAX    = 64;    // cycles allowed before response start bit

    localparam int CMD_FRAME_W  = 48;  // command and short response
    localparam int LONG_FRAME_W = 136;
    localparam int CRC_BODY_W   = 40;  // leading bits covered by crc7
    localparam int LONG_HDR_W   = 8;
    localparam int CRC_W        = 7;
    localparam int CNT_W        = 8;

    localparam logic [APB_ADDR_W-1:0] REG_ARGUMENT      = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_COMMAND       = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_RESP0         = 8'h10;
    localparam logic [APB_ADDR_W-1:0] REG_RESP1         = 8'h14;
    localparam logic [APB_ADDR_W-1:0] REG_RESP2         = 8'h18;
    localparam logic [APB_ADDR_W-1:0] REG_RESP3         = 8'h1C;
    localparam logic [APB_ADDR_W-1:0] REG_PRESENT       = 8'h20;
    localparam logic [APB_ADDR_W-1:0] REG_INT_STATUS    = 8'h24;
    localparam logic [APB_ADDR_W-1:0] REG_INT_STATUS_EN = 8'h28;
    localparam logic [APB_ADDR_W-1:0] REG_INT_SIGNAL_EN = 8'h2C;
    localparam logic [APB_ADDR_W-1:0] REG_SOFT_RESET    = 8'h30;

    // command register fields
    localparam int CMD_REG_W      = 12;
    localparam int CMD_RTYPE_LSB  = 8;
    localparam int CMD_CRC_EN_BIT = 10;
    localparam int CMD_IDX_EN_BIT = 11;

    localparam int INT_W         = 5;
    localparam int INT_CMD_DONE  = 0;
    localparam int INT_TIMEOUT   = 1;
    localparam int INT_CRC_ERR   = 2;
    localparam int INT_INDEX_ERR = 3;
    localparam int INT_MISMATCH  = 4;

    typedef enum logic [1:0] {
        RESP_NONE,
        RESP_SHORT,
        RESP_LONG
    } resp_type_e;

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT_RESP,
        RECEIVE,
        FINISH
    } host_state_e;

    typedef struct packed {
        logic [CMD_IDX_W-1:0] index;
        logic [ARG_W-1:0]     argument;
        resp_type_e           resp_type;
        logic                 crc_chk;
        logic                 idx_chk;
    } cmd_req_t;

    typedef struct packed {
        logic [RESP_W-1:0] response;
        logic              timeout;
        logic              crc_err;
        logic              index_err;
    } cmd_result_t;

    typedef struct packed {
        logic [APB_ADDR_W-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage

// File: logic/sd_apb_regs.sv
`timescale 1ns/1ps

module sd_apb_regs import sd_pkg::*; (
    input  logic              sd_clk_i,
    input  logic              rst_n_i,
    input  apb_req_t          apb_i,
    output apb_rsp_t          apb_o,
    input  logic              cmd_inhibit_i,
    input  logic              upd_valid_i,
    input  logic [RESP_W-1:0] upd_resp_i,
    input  logic [INT_W-1:0]  upd_status_i,
    output logic              cmd_start_o,
    output cmd_req_t          cmd_req_o,
    output logic              soft_rst_o,
    output logic              interrupt_o
);

    logic                  access;
    logic                  wr;
    logic                  cmd_wr;
    logic [INT_W-1:0]      int_clr;
    logic [INT_W-1:0]      int_set;

    logic [ARG_W-1:0]      argument_q;
    logic [CMD_REG_W-1:0]  command_q;
    logic [RESP_W-1:0]     resp_q;
    logic [INT_W-1:0]      int_status_q;
    logic [INT_W-1:0]      int_status_en_q;
    logic [INT_W-1:0]      int_signal_en_q;
    logic                  cmd_start_q;
    logic                  soft_rst_q;
    logic [APB_DATA_W-1:0] rdata;

    assign access = apb_i.psel & apb_i.penable;
    assign wr     = access & apb_i.pwrite;
    assign cmd_wr = wr && (apb_i.paddr == REG_COMMAND);

    // write one clears, a fresh event in the same cycle wins
    assign int_clr = (wr && apb_i.paddr == REG_INT_STATUS) ? apb_i.pwdata[INT_W-1:0] : '0;
    assign int_set = upd_valid_i ? (upd_status_i & int_status_en_q) : '0;

    always_ff @(posedge sd_clk_i) begin
        if (!rst_n_i) begin
            argument_q      <= '0;
            command_q       <= '0;
            resp_q          <= '0;
            int_status_q    <= '0;
            int_status_en_q <= '0;
            int_signal_en_q <= '0;
            cmd_start_q     <= 1'b0;
            soft_rst_q      <= 1'b0;
        end else begin
            cmd_start_q  <= cmd_wr & ~cmd_inhibit_i;
            soft_rst_q   <= wr && (apb_i.paddr == REG_SOFT_RESET) && apb_i.pwdata[0];
            int_status_q <= (int_status_q & ~int_clr) | int_set;
            if (upd_valid_i) begin
                resp_q <= upd_resp_i;
            end
            if (cmd_wr && !cmd_inhibit_i) begin
                command_q <= {apb_i.pwdata[CMD_IDX_EN_BIT:CMD_RTYPE_LSB], 2'b00,
                              apb_i.pwdata[CMD_IDX_W-1:0]};
            end
            if (wr) begin
                case (apb_i.paddr)
                    REG_ARGUMENT:      argument_q      <= apb_i.pwdata;
                    REG_INT_STATUS_EN: int_status_en_q <= apb_i.pwdata[INT_W-1:0];
                    REG_INT_SIGNAL_EN: int_signal_en_q <= apb_i.pwdata[INT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (apb_i.paddr)
            REG_ARGUMENT:      rdata = argument_q;
            REG_COMMAND:       rdata = {{(APB_DATA_W-CMD_REG_W){1'b0}}, command_q};
            REG_RESP0:         rdata = resp_q[31:0];
            REG_RESP1:         rdata = resp_q[63:32];
            REG_RESP2:         rdata = resp_q[95:64];
            REG_RESP3:         rdata = {{(4*APB_DATA_W-RESP_W){1'b0}}, resp_q[RESP_W-1:96]};
            REG_PRESENT:       rdata = {{(APB_DATA_W-1){1'b0}}, cmd_inhibit_i};
            REG_INT_STATUS:    rdata = {{(APB_DATA_W-INT_W){1'b0}}, int_status_q};
            REG_INT_STATUS_EN: rdata = {{(APB_DATA_W-INT_W){1'b0}}, int_status_en_q};
            REG_INT_SIGNAL_EN: rdata = {{(APB_DATA_W-INT_W){1'b0}}, int_signal_en_q};
            default:           rdata = '0;   // soft reset and holes read zero
        endcase
    end

    always_comb begin
        apb_o.prdata  = rdata;
        apb_o.pready  = access;                  // never waits
        apb_o.pslverr = cmd_wr & cmd_inhibit_i;  // busy, write dropped
    end

    always_comb begin
        cmd_req_o.index     = command_q[CMD_IDX_W-1:0];
        cmd_req_o.argument  = argument_q;
        cmd_req_o.resp_type = resp_type_e'(command_q[CMD_RTYPE_LSB +: 2]);
        cmd_req_o.crc_chk   = command_q[CMD_CRC_EN_BIT];
        cmd_req_o.idx_chk   = command_q[CMD_IDX_EN_BIT];
    end

    assign cmd_start_o = cmd_start_q;
    assign soft_rst_o  = soft_rst_q;
    assign interrupt_o = |(int_status_q & int_signal_en_q);

endmodule

// File: logic/sd_cmd_serial_host.sv
`timescale 1ns/1ps

module sd_cmd_serial_host import sd_pkg::*; (
    input  logic        sd_clk_i,
    input  logic        rst_n_i,
    input  logic        soft_rst_i,
    input  logic        start_i,
    input  cmd_req_t    req_i,
    input  logic        cmd_i,
    output logic        cmd_o,
    output logic        cmd_oe_o,
    output logic        done_o,
    output cmd_result_t result_o
);

    host_state_e              state_q;
    logic [CNT_W-1:0]         cnt_q;
    logic                     cmd_q;
    logic                     oe_q;
    logic                     timeout_q;

    logic [LONG_FRAME_W-1:0]  shift_q;
    logic [CRC_W-1:0]         crc_q;
    logic [CMD_IDX_W-1:0]     idx_q;
    resp_type_e               type_q;
    logic                     crc_chk_q;
    logic                     idx_chk_q;

    logic [CNT_W-1:0]         last_bit;
    logic                     crc_window;
    logic                     crc_bad;

    // serial crc7, x^7 + x^3 + 1
    function automatic logic [CRC_W-1:0] crc7_next(input logic [CRC_W-1:0] crc,
                                                   input logic bit_in);
        logic fb;
        fb = crc[CRC_W-1] ^ bit_in;
        return {crc[CRC_W-2:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    assign last_bit = (type_q == RESP_LONG) ? CNT_W'(LONG_FRAME_W - 1) : CNT_W'(CMD_FRAME_W - 1);
    assign crc_window = (type_q == RESP_LONG) ?
                        (cnt_q >= LONG_HDR_W && cnt_q < LONG_HDR_W + RESP_W) :
                        (cnt_q < CRC_BODY_W);

    always_ff @(posedge sd_clk_i) begin
        if (!rst_n_i || soft_rst_i) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            cmd_q     <= 1'b1;
            oe_q      <= 1'b0;
            timeout_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (start_i) begin
                    state_q   <= SEND;
                    cmd_q     <= 1'b0;   // start bit
                    oe_q      <= 1'b1;
                    cnt_q     <= CNT_W'(1);
                    timeout_q <= 1'b0;
                end
                SEND: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q < CRC_BODY_W) begin
                        cmd_q <= shift_q[LONG_FRAME_W-1];
                    end else if (cnt_q < CMD_FRAME_W - 1) begin
                        cmd_q <= crc_q[CRC_W-1];
                    end else if (cnt_q == CMD_FRAME_W - 1) begin
                        cmd_q <= 1'b1;   // end bit
                    end else begin
                        oe_q    <= 1'b0;
                        cnt_q   <= '0;
                        state_q <= (type_q == RESP_NONE) ? FINISH : WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (!cmd_i) begin
                        state_q <= RECEIVE;
                        cnt_q   <= CNT_W'(1);
                    end else if (cnt_q == NCR_MAX - 1) begin
                        timeout_q <= 1'b1;
                        state_q   <= FINISH;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RECEIVE: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == last_bit) state_q <= FINISH;
                end
                FINISH: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // frame shifter and crc, shared by both directions
    always_ff @(posedge sd_clk_i) begin
        if (state_q == IDLE && start_i) begin
            shift_q   <= {1'b1, req_i.index, req_i.argument,
                          {(LONG_FRAME_W - CRC_BODY_W + 1){1'b0}}};
            crc_q     <= '0;
            idx_q     <= req_i.index;
            type_q    <= req_i.resp_type;
            crc_chk_q <= req_i.crc_chk;
            idx_chk_q <= req_i.idx_chk;
        end else if (state_q == SEND) begin
            if (cnt_q < CRC_BODY_W) begin
                shift_q <= {shift_q[LONG_FRAME_W-2:0], 1'b0};
                crc_q   <= crc7_next(crc_q, shift_q[LONG_FRAME_W-1]);
            end else begin
                crc_q <= crc7_next(crc_q, crc_q[CRC_W-1]);   // plain shift out
            end
        end else if (state_q == WAIT_RESP && !cmd_i) begin
            shift_q <= {shift_q[LONG_FRAME_W-2:0], 1'b0};
            crc_q   <= '0;
        end else if (state_q == RECEIVE) begin
            shift_q <= {shift_q[LONG_FRAME_W-2:0], cmd_i};
            if (crc_window) crc_q <= crc7_next(crc_q, cmd_i);
        end
    end

    assign crc_bad = crc_chk_q && (shift_q[CRC_W:1] != crc_q);

    always_comb begin
        result_o         = '0;
        result_o.timeout = timeout_q;
        if (!timeout_q) begin
            case (type_q)
                RESP_SHORT: begin
                    result_o.response  = {{(RESP_W-ARG_W){1'b0}}, shift_q[CRC_W+1 +: ARG_W]};
                    result_o.crc_err   = crc_bad;
                    result_o.index_err = idx_chk_q &&
                                         (shift_q[CMD_FRAME_W-3 -: CMD_IDX_W] != idx_q);
                end
                RESP_LONG: begin
                    result_o.response = shift_q[CRC_W+1 +: RESP_W];
                    result_o.crc_err  = crc_bad;
                end
                default: ;
            endcase
        end
    end

    assign done_o   = (state_q == FINISH);
    assign cmd_o    = cmd_q;
    assign cmd_oe_o = oe_q;

endmodule

// File: logic/sd_cmd_raid0.sv
`timescale 1ns/1ps

module sd_cmd_raid0 import sd_pkg::*; (
    input  logic              sd_clk_i,
    input  logic              rst_n_i,
    input  logic              soft_rst_i,
    input  logic              cmd_start_i,
    input  logic              done0_i,
    input  logic              done1_i,
    input  cmd_result_t       result0_i,
    input  cmd_result_t       result1_i,
    output logic              host_start_o,
    output logic              cmd_inhibit_o,
    output logic              upd_valid_o,
    output logic [RESP_W-1:0] upd_resp_o,
    output logic [INT_W-1:0]  upd_status_o
);

    logic        host_start_q;
    logic        inhibit_q;
    logic [1:0]  fin_q;
    logic        upd_valid_q;
    logic [1:0]  fin_nxt;

    cmd_result_t res0_q;
    cmd_result_t res1_q;
    logic        any_timeout;
    logic        any_crc_err;
    logic        any_idx_err;
    logic        mismatch;

    assign fin_nxt = fin_q | {done1_i, done0_i};

    always_ff @(posedge sd_clk_i) begin
        if (!rst_n_i || soft_rst_i) begin
            host_start_q <= 1'b0;
            inhibit_q    <= 1'b0;
            fin_q        <= '0;
            upd_valid_q  <= 1'b0;
        end else begin
            host_start_q <= cmd_start_i;   // same frame goes to both cards
            upd_valid_q  <= 1'b0;
            if (cmd_start_i) begin
                inhibit_q <= 1'b1;
                fin_q     <= '0;
            end else if (upd_valid_q) begin
                inhibit_q <= 1'b0;   // drops together with the status write
            end else if (inhibit_q && !(&fin_q)) begin
                fin_q       <= fin_nxt;
                upd_valid_q <= &fin_nxt;
            end
        end
    end

    // each card's result, held until the slower one is done
    always_ff @(posedge sd_clk_i) begin
        if (done0_i) res0_q <= result0_i;
        if (done1_i) res1_q <= result1_i;
    end

    assign any_timeout = res0_q.timeout | res1_q.timeout;
    assign any_crc_err = res0_q.crc_err | res1_q.crc_err;
    assign any_idx_err = res0_q.index_err | res1_q.index_err;
    assign mismatch    = !any_timeout && (res0_q.response != res1_q.response);

    always_comb begin
        upd_status_o                = '0;
        upd_status_o[INT_TIMEOUT]   = any_timeout;
        upd_status_o[INT_CRC_ERR]   = any_crc_err;
        upd_status_o[INT_INDEX_ERR] = any_idx_err;
        upd_status_o[INT_MISMATCH]  = mismatch;
        upd_status_o[INT_CMD_DONE]  = !(any_timeout | any_crc_err | any_idx_err | mismatch);
    end

    assign upd_resp_o    = res0_q.response;   // card 0 is the reference copy
    assign upd_valid_o   = upd_valid_q;
    assign host_start_o  = host_start_q;
    assign cmd_inhibit_o = inhibit_q;

endmodule

// File: logic/sd_emmc_controller.sv
`timescale 1ns/1ps

module sd_emmc_controller import sd_pkg::*; (
    input  logic     sd_clk_i,
    input  logic     rst_n_i,
    input  apb_req_t apb_i,
    output apb_rsp_t apb_o,
    input  logic     sd_cmd0_i,
    output logic     sd_cmd0_o,
    output logic     sd_cmd0_oe_o,
    input  logic     sd_cmd1_i,
    output logic     sd_cmd1_o,
    output logic     sd_cmd1_oe_o,
    output logic     interrupt_o
);

    logic              cmd_start;
    cmd_req_t          cmd_req;
    logic              soft_rst;
    logic              cmd_inhibit;
    logic              host_start;
    logic              upd_valid;
    logic [RESP_W-1:0] upd_resp;
    logic [INT_W-1:0]  upd_status;
    logic              done0;
    logic              done1;
    cmd_result_t       result0;
    cmd_result_t       result1;

    sd_apb_regs regs_inst (
        .sd_clk_i      (sd_clk_i),
        .rst_n_i       (rst_n_i),
        .apb_i         (apb_i),
        .apb_o         (apb_o),
        .cmd_inhibit_i (cmd_inhibit),
        .upd_valid_i   (upd_valid),
        .upd_resp_i    (upd_resp),
        .upd_status_i  (upd_status),
        .cmd_start_o   (cmd_start),
        .cmd_req_o     (cmd_req),
        .soft_rst_o    (soft_rst),
        .interrupt_o   (interrupt_o)
    );

    sd_cmd_raid0 raid0_inst (
        .sd_clk_i      (sd_clk_i),
        .rst_n_i       (rst_n_i),
        .soft_rst_i    (soft_rst),
        .cmd_start_i   (cmd_start),
        .done0_i       (done0),
        .done1_i       (done1),
        .result0_i     (result0),
        .result1_i     (result1),
        .host_start_o  (host_start),
        .cmd_inhibit_o (cmd_inhibit),
        .upd_valid_o   (upd_valid),
        .upd_resp_o    (upd_resp),
        .upd_status_o  (upd_status)
    );

    sd_cmd_serial_host cmd_host0 (
        .sd_clk_i   (sd_clk_i),
        .rst_n_i    (rst_n_i),
        .soft_rst_i (soft_rst),
        .start_i    (host_start),
        .req_i      (cmd_req),
        .cmd_i      (sd_cmd0_i),
        .cmd_o      (sd_cmd0_o),
        .cmd_oe_o   (sd_cmd0_oe_o),
        .done_o     (done0),
        .result_o   (result0)
    );

    sd_cmd_serial_host cmd_host1 (
        .sd_clk_i   (sd_clk_i),
        .rst_n_i    (rst_n_i),
        .soft_rst_i (soft_rst),
        .start_i    (host_start),
        .req_i      (cmd_req),
        .cmd_i      (sd_cmd1_i),
        .cmd_o      (sd_cmd1_o),
        .cmd_oe_o   (sd_cmd1_oe_o),
        .done_o     (done1),
        .result_o   (result1)
    );

endmodule

// File: tb/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model import sd_pkg::*; (
    input  logic     clk_i,
    input  logic     cmd_i,
    input  logic     oe_i,
    output logic     cmd_o,
    output cmd_req_t rx_req_o,
    output logic     rx_ok_o
);

    logic              respond;
    logic              long_ans;
    logic              bad_crc;
    logic              bad_idx;
    logic [RESP_W-1:0] value;

    logic [47:0]       rx;
    logic [135:0]      tx;
    logic [6:0]        crc;
    logic [5:0]        idx;
    int                len;
    int                n;

    task automatic set_answer(input logic resp_en, input logic long_en,
                              input logic [RESP_W-1:0] val, input logic crc_bad,
                              input logic idx_bad);
        respond  = resp_en;
        long_ans = long_en;
        value    = val;
        bad_crc  = crc_bad;
        bad_idx  = idx_bad;
    endtask

    // x^7 + x^3 + 1 over bits[len-1:0], msb first
    function automatic logic [6:0] crc7(input logic [135:0] bits, input int len);
        logic [6:0] c;
        logic       fb;
        int         i;
        c = '0;
        for (i = len - 1; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) c = c ^ 7'h09;
        end
        return c;
    endfunction

    initial begin
        cmd_o    = 1'b1;   // line idles high
        rx_req_o = '0;
        rx_ok_o  = 1'b0;
        respond  = 1'b0;
        long_ans = 1'b0;
        value    = '0;
        bad_crc  = 1'b0;
        bad_idx  = 1'b0;
        forever begin
            @(negedge clk_i);
            if (oe_i && !cmd_i) begin
                rx = '0;   // start bit already seen
                for (n = 46; n >= 0; n--) begin
                    @(negedge clk_i);
                    rx[n] = cmd_i;
                end
                rx_req_o          = '0;
                rx_req_o.index    = rx[45:40];
                rx_req_o.argument = rx[39:8];
                rx_ok_o = rx[46] && rx[0] && (rx[7:1] == crc7(136'(rx[47:8]), 40));
                if (respond) begin
                    idx = bad_idx ? ~rx[45:40] : rx[45:40];
                    if (long_ans) begin
                        len = 136;
                        crc = crc7(136'(value), 120) ^ {6'b0, bad_crc};
                        tx  = {2'b00, 6'h3F, value, crc, 1'b1};
                    end else begin
                        len = 48;
                        crc = crc7(136'({2'b00, idx, value[31:0]}), 40) ^ {6'b0, bad_crc};
                        tx  = 136'({2'b00, idx, value[31:0], crc, 1'b1});
                    end
                    repeat (2) @(posedge clk_i);   // short ncr gap
                    for (n = len - 1; n >= 0; n--) begin
                        @(posedge clk_i);
                        cmd_o <= tx[n];
                    end
                    @(posedge clk_i);
                    cmd_o <= 1'b1;
                end
            end
        end
    end

endmodule

// File: tb/tb_sd_emmc_controller.sv
`timescale 1ns/1ps

module tb_sd_emmc_controller import sd_pkg::*; ();

    logic     clk;
    logic     rst_n;
    apb_req_t apb;
    apb_rsp_t apb_rsp;
    logic     sd_cmd0_i;
    logic     sd_cmd0_o;
    logic     sd_cmd0_oe;
    logic     sd_cmd1_i;
    logic     sd_cmd1_o;
    logic     sd_cmd1_oe;
    logic     interrupt;
    cmd_req_t rx_req0;
    cmd_req_t rx_req1;
    logic     rx_ok0;
    logic     rx_ok1;
    int       errors;
    int       seed;
    logic     last_slverr;
    string    cur_test;

    sd_emmc_controller uut (
        .sd_clk_i     (clk),
        .rst_n_i      (rst_n),
        .apb_i        (apb),
        .apb_o        (apb_rsp),
        .sd_cmd0_i    (sd_cmd0_i),
        .sd_cmd0_o    (sd_cmd0_o),
        .sd_cmd0_oe_o (sd_cmd0_oe),
        .sd_cmd1_i    (sd_cmd1_i),
        .sd_cmd1_o    (sd_cmd1_o),
        .sd_cmd1_oe_o (sd_cmd1_oe),
        .interrupt_o  (interrupt)
    );

    sd_card_model card0 (
        .clk_i    (clk),
        .cmd_i    (sd_cmd0_o),
        .oe_i     (sd_cmd0_oe),
        .cmd_o    (sd_cmd0_i),
        .rx_req_o (rx_req0),
        .rx_ok_o  (rx_ok0)
    );

    sd_card_model card1 (
        .clk_i    (clk),
        .cmd_i    (sd_cmd1_o),
        .oe_i     (sd_cmd1_oe),
        .cmd_o    (sd_cmd1_i),
        .rx_req_o (rx_req1),
        .rx_ok_o  (rx_ok1)
    );

    always #5 clk = ~clk;

    task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_status(input string name, input logic [INT_W-1:0] exp,
                                  input logic [INT_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_frame(input string name, input cmd_req_t exp, input cmd_req_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb.paddr   <= addr;
        apb.pwdata  <= data;
        apb.pwrite  <= 1'b1;
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        last_slverr = apb_rsp.pslverr;
        compare_bit($sformatf("%s write pready", cur_test), 1'b1, apb_rsp.pready);
        @(posedge clk);   // write lands on this edge
        apb.psel    <= 1'b0;
        apb.penable <= 1'b0;
        apb.pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        apb.paddr   <= addr;
        apb.pwrite  <= 1'b0;
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        compare_bit($sformatf("%s read pready", cur_test), 1'b1, apb_rsp.pready);
        @(posedge clk);
        apb.psel    <= 1'b0;
        apb.penable <= 1'b0;
    endtask

    task automatic issue_cmd(input logic [CMD_IDX_W-1:0] idx, input resp_type_e rtype,
                             input logic crc_chk, input logic idx_chk);
        logic [31:0] word;
        word                                = '0;
        word[CMD_IDX_W-1:0]                 = idx;
        word[CMD_RTYPE_LSB +: 2]            = rtype;
        word[CMD_CRC_EN_BIT]                = crc_chk;
        word[CMD_IDX_EN_BIT]                = idx_chk;
        apb_write(REG_COMMAND, word);
    endtask

    task automatic wait_idle(input string name);
        logic [31:0] present;
        int          polls;
        polls = 0;
        apb_read(REG_PRESENT, present);
        while (present[0] && polls < 300) begin
            apb_read(REG_PRESENT, present);
            polls++;
        end
        if (present[0]) begin
            $display("ERROR %s: command inhibit still set after %0d polls", name, polls);
            errors++;
        end
    endtask

    task automatic await_oe_level(input string name, input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (sd_cmd0_oe !== level && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (sd_cmd0_oe !== level) begin
            $display("ERROR %s: card 0 output enable never went to %b", name, level);
            errors++;
        end
    endtask

    // random argument and index, then the combined status
    task automatic send_and_check(input string name, input resp_type_e rtype,
                                  input logic crc_chk, input logic idx_chk,
                                  input logic [INT_W-1:0] exp);
        logic [31:0] rd;
        apb_write(REG_ARGUMENT, $random(seed));
        issue_cmd(CMD_IDX_W'($random(seed)), rtype, crc_chk, idx_chk);
        wait_idle(name);
        apb_read(REG_INT_STATUS, rd);
        compare_status(name, exp, rd[INT_W-1:0]);
        apb_write(REG_INT_STATUS, 32'h1F);
    endtask

    task automatic reset_values();
        logic [31:0] rd;
        int          a;
        cur_test = "reset";
        for (a = 0; a <= 'h30; a += 4) begin   // holes included
            apb_read(APB_ADDR_W'(a), rd);
            compare_word($sformatf("reset reg %02h", a), 32'h0, rd);
        end
        @(negedge clk);
        compare_bit("reset interrupt", 1'b0, interrupt);
        compare_bit("reset oe0", 1'b0, sd_cmd0_oe);
        compare_bit("reset oe1", 1'b0, sd_cmd1_oe);
        compare_bit("reset cmd0", 1'b1, sd_cmd0_o);
        compare_bit("reset cmd1", 1'b1, sd_cmd1_o);
    endtask

    task automatic no_response_cmd();
        logic [ARG_W-1:0]     arg;
        logic [CMD_IDX_W-1:0] idx;
        cmd_req_t             exp;
        logic [31:0]          rd;
        cur_test = "no_response";
        arg = $random(seed);
        idx = CMD_IDX_W'($random(seed));
        card0.set_answer(1'b0, 1'b0, '0, 1'b0, 1'b0);
        card1.set_answer(1'b0, 1'b0, '0, 1'b0, 1'b0);
        apb_write(REG_INT_STATUS_EN, 32'h1F);
        apb_write(REG_ARGUMENT, arg);
        issue_cmd(idx, RESP_NONE, 1'b0, 1'b0);
        compare_bit("no_response accepted pslverr", 1'b0, last_slverr);
        issue_cmd(~idx, RESP_LONG, 1'b1, 1'b1);   // lands while busy
        compare_bit("no_response busy pslverr", 1'b1, last_slverr);
        wait_idle("no_response");
        exp          = '0;
        exp.index    = idx;
        exp.argument = arg;
        compare_frame("no_response card0 frame", exp, rx_req0);
        compare_frame("no_response card1 frame", exp, rx_req1);
        compare_bit("no_response card0 framing", 1'b1, rx_ok0);
        compare_bit("no_response card1 framing", 1'b1, rx_ok1);
        apb_read(REG_COMMAND, rd);
        compare_word("no_response command kept", 32'(idx), rd);
        apb_read(REG_INT_STATUS, rd);
        compare_status("no_response status", 5'b00001, rd[INT_W-1:0]);
        apb_read(REG_PRESENT, rd);
        compare_word("no_response present", 32'h0, rd);
        apb_write(REG_INT_STATUS, 32'h1F);
    endtask

    task automatic short_response_cmd();
        logic [31:0] status;
        logic [31:0] rd;
        cur_test = "short_response";
        status = $random(seed);
        card0.set_answer(1'b1, 1'b0, RESP_W'(status), 1'b0, 1'b0);
        card1.set_answer(1'b1, 1'b0, RESP_W'(status), 1'b0, 1'b0);
        apb_write(REG_INT_SIGNAL_EN, 32'h0);
        apb_write(REG_ARGUMENT, $random(seed));
        issue_cmd(CMD_IDX_W'($random(seed)), RESP_SHORT, 1'b1, 1'b1);
        wait_idle("short_response");
        apb_read(REG_RESP0, rd);
        compare_word("short_response resp0", status, rd);
        apb_read(REG_INT_STATUS, rd);
        compare_status("short_response status", 5'b00001, rd[INT_W-1:0]);
        @(negedge clk);
        compare_bit("short_response irq masked", 1'b0, interrupt);
        apb_write(REG_INT_SIGNAL_EN, 32'h1);
        @(negedge clk);
        compare_bit("short_response irq enabled", 1'b1, interrupt);
        apb_write(REG_INT_STATUS, 32'h1);
        @(negedge clk);
        compare_bit("short_response irq cleared", 1'b0, interrupt);
        apb_read(REG_INT_STATUS, rd);
        compare_status("short_response status cleared", 5'b00000, rd[INT_W-1:0]);
    endtask

    task automatic long_response_cmd();
        logic [RESP_W-1:0] value;
        logic [31:0]       rd;
        cur_test = "long_response";
        value = RESP_W'({$random(seed), $random(seed), $random(seed), $random(seed)});
        card0.set_answer(1'b1, 1'b1, value, 1'b0, 1'b0);
        card1.set_answer(1'b1, 1'b1, value, 1'b0, 1'b0);
        send_and_check("long_response", RESP_LONG, 1'b1, 1'b0, 5'b00001);
        apb_read(REG_RESP0, rd);
        compare_word("long_response resp0", value[31:0], rd);
        apb_read(REG_RESP1, rd);
        compare_word("long_response resp1", value[63:32], rd);
        apb_read(REG_RESP2, rd);
        compare_word("long_response resp2", value[95:64], rd);
        apb_read(REG_RESP3, rd);
        compare_word("long_response resp3", 32'(value[119:96]), rd);
    endtask

    task automatic error_cases();
        logic [RESP_W-1:0] status;
        logic [31:0]       rd;
        cur_test = "errors";
        status = RESP_W'(32'($random(seed)));
        card0.set_answer(1'b1, 1'b0, status, 1'b0, 1'b0);
        card1.set_answer(1'b0, 1'b0, '0, 1'b0, 1'b0);
        send_and_check("error timeout", RESP_SHORT, 1'b1, 1'b1, 5'b00010);
        card0.set_answer(1'b1, 1'b0, status, 1'b1, 1'b0);
        card1.set_answer(1'b1, 1'b0, status, 1'b0, 1'b0);
        send_and_check("error crc", RESP_SHORT, 1'b1, 1'b0, 5'b00100);
        card0.set_answer(1'b1, 1'b0, status, 1'b0, 1'b0);
        card1.set_answer(1'b1, 1'b0, status, 1'b0, 1'b1);
        send_and_check("error index", RESP_SHORT, 1'b1, 1'b1, 5'b01000);
        card1.set_answer(1'b1, 1'b0, status ^ 1, 1'b0, 1'b0);
        send_and_check("error mismatch", RESP_SHORT, 1'b1, 1'b1, 5'b10000);

        card1.set_answer(1'b0, 1'b0, '0, 1'b0, 1'b0);
        apb_write(REG_INT_STATUS_EN, 32'h1D);   // timeout not recorded
        send_and_check("error timeout masked", RESP_SHORT, 1'b1, 1'b1, 5'b00000);
        apb_write(REG_INT_STATUS_EN, 32'h1F);

        // abort while both hosts wait for a response
        card0.set_answer(1'b0, 1'b0, '0, 1'b0, 1'b0);
        apb_write(REG_ARGUMENT, $random(seed));
        issue_cmd(CMD_IDX_W'($random(seed)), RESP_SHORT, 1'b1, 1'b1);
        await_oe_level("soft_reset frame start", 1'b1);
        await_oe_level("soft_reset frame end", 1'b0);
        apb_write(REG_SOFT_RESET, 32'h1);
        apb_read(REG_PRESENT, rd);
        compare_word("soft_reset present", 32'h0, rd);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        apb         = '0;
        errors      = 0;
        seed        = 32'h800b_89b4;
        last_slverr = 1'b0;
        cur_test    = "reset";
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        reset_values();
        no_response_cmd();
        short_response_cmd();
        long_response_cmd();
        error_cases();

        $display("checks complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
logic/sd_pkg.sv
logic/sd_apb_regs.sv
logic/sd_cmd_serial_host.sv
logic/sd_cmd_raid0.sv
logic/sd_emmc_controller.sv
tb/sd_card_model.sv
tb/tb_sd_emmc_controller.sv

// File: Makefile
TOP := tb_sd_emmc_controller

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
